//--- hw/cpuPkg.sv
// shared definitions for the five-stage core
// data, address and register index widths
// instruction field positions and the nop word
// opcodes, ALU and branch operation codes
// forward select codes
package cpuPkg;

    localparam int dataWidth     = 32;
    localparam int addrWidth     = 9;
    localparam int regAddrWidth  = 4;
    localparam int numRegs       = 16;
    localparam int aluOpWidth    = 4;
    localparam int branchOpWidth = 3;
    localparam int fwdWidth      = 2;

    // instruction word fields
    localparam int opcodeMsb = 31;
    localparam int opcodeLsb = 28;
    localparam int funcMsb   = 27;
    localparam int funcLsb   = 24;
    localparam int signedBit = 24;
    localparam int constMsb  = 23;
    localparam int constLsb  = 12;
    localparam int aregMsb   = 11;
    localparam int aregLsb   = 8;
    localparam int bregMsb   = 7;
    localparam int bregLsb   = 4;
    localparam int dregMsb   = 3;
    localparam int dregLsb   = 0;

    // opcodes, any value not listed behaves as nop
    localparam logic [3:0] opNop    = 4'd0;
    localparam logic [3:0] opArith  = 4'd1;
    localparam logic [3:0] opArithC = 4'd2;
    localparam logic [3:0] opBranch = 4'd3;
    localparam logic [3:0] opJump   = 4'd4;
    localparam logic [3:0] opJumpR  = 4'd5;
    localparam logic [3:0] opHalt   = 4'd6;

    localparam logic [dataWidth-1:0] nopWord = {opNop, {(dataWidth - 4){1'b0}}};

    localparam logic [aluOpWidth-1:0] aluAdd = 4'd0;
    localparam logic [aluOpWidth-1:0] aluSub = 4'd1;
    localparam logic [aluOpWidth-1:0] aluAnd = 4'd2;
    localparam logic [aluOpWidth-1:0] aluOr  = 4'd3;
    localparam logic [aluOpWidth-1:0] aluXor = 4'd4;
    localparam logic [aluOpWidth-1:0] aluShl = 4'd5;
    localparam logic [aluOpWidth-1:0] aluShr = 4'd6;
    localparam logic [aluOpWidth-1:0] aluSlt = 4'd7;

    // branch compares, codes 3 and 7 never branch
    localparam logic [branchOpWidth-1:0] brEq = 3'd0;
    localparam logic [branchOpWidth-1:0] brGt = 3'd1;
    localparam logic [branchOpWidth-1:0] brGe = 3'd2;
    localparam logic [branchOpWidth-1:0] brNe = 3'd4;
    localparam logic [branchOpWidth-1:0] brLt = 3'd5;
    localparam logic [branchOpWidth-1:0] brLe = 3'd6;

    localparam logic [fwdWidth-1:0] fwdNone = 2'd0;
    localparam logic [fwdWidth-1:0] fwdMem  = 2'd1;
    localparam logic [fwdWidth-1:0] fwdWb   = 2'd2;

endpackage

//--- hw/instrDecoder.sv
`timescale 1ns/1ps
// instruction decoder and control flags
// field extraction and const12 sign extension
// per-opcode register write, branch, jump and halt flags
module instrDecoder (
    input  logic [cpuPkg::dataWidth-1:0]     instr,
    output logic [cpuPkg::aluOpWidth-1:0]    aluOp,
    output logic [cpuPkg::branchOpWidth-1:0] branchOp,
    output logic                             isSigned,
    output logic [cpuPkg::dataWidth-1:0]     const12Ext,
    output logic [cpuPkg::regAddrWidth-1:0]  areg,
    output logic [cpuPkg::regAddrWidth-1:0]  breg,
    output logic [cpuPkg::regAddrWidth-1:0]  dreg,
    output logic                             useConst,
    output logic                             regWe,
    output logic                             isBranch,
    output logic                             isJump,
    output logic                             isJumpR,
    output logic                             isHalt
);
    import cpuPkg::*;

    logic [3:0] opcode;
    logic       writesReg;

    assign opcode   = instr[opcodeMsb:opcodeLsb];
    assign aluOp    = instr[funcMsb:funcLsb];
    // branch compare sits above the signed flag
    assign branchOp = instr[funcMsb -: branchOpWidth];
    assign isSigned = instr[signedBit];
    assign areg     = instr[aregMsb:aregLsb];
    assign breg     = instr[bregMsb:bregLsb];
    assign dreg     = instr[dregMsb:dregLsb];

    assign const12Ext = {{(dataWidth - (constMsb - constLsb + 1)){instr[constMsb]}},
                         instr[constMsb:constLsb]};

    always_comb
    begin
        writesReg = 1'b0;
        useConst  = 1'b0;
        isBranch  = 1'b0;
        isJump    = 1'b0;
        isJumpR   = 1'b0;
        isHalt    = 1'b0;
        case (opcode)
            opArith:  writesReg = 1'b1;
            opArithC:
            begin
                writesReg = 1'b1;
                useConst  = 1'b1;
            end
            opBranch: isBranch = 1'b1;
            opJump:   isJump   = 1'b1;
            opJumpR:  isJumpR  = 1'b1;
            opHalt:   isHalt   = 1'b1;
            default:  writesReg = 1'b0;
        endcase
    end

    // a write to register 0 is dropped here
    assign regWe = writesReg && (dreg != '0);

endmodule

//--- hw/programCounter.sv
`timescale 1ns/1ps
// program counter for the fetch stage
// sequential step or redirect load from MEM
// sticky halted flag
module programCounter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         redirect,
    input  logic [cpuPkg::addrWidth-1:0] redirectAddr,
    input  logic                         haltMem,
    output logic [cpuPkg::addrWidth-1:0] romAddr,
    output logic                         halted
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            romAddr <= '0;
            halted  <= 1'b0;
        end
        else
        begin
            // redirect from MEM wins over the step
            if (redirect)
                romAddr <= redirectAddr;
            else
                romAddr <= romAddr + 1'b1;
            if (haltMem)
                halted <= 1'b1;
        end
    end

    // a halt in MEM was on romAddr three edges earlier and must loop back there
    haltLoopsToSelf: assert property (@(posedge clk) disable iff (reset)
        (haltMem && !halted) |-> (redirect && redirectAddr == $past(romAddr, 3)));

endmodule

//--- hw/regBank.sv
`timescale 1ns/1ps
// sixteen-entry register file
// registered reads toward EX, cleared on flush
// write port from WB with pass-through to a same-cycle read
module regBank (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpuPkg::regAddrWidth-1:0] aregAddr,
    input  logic [cpuPkg::regAddrWidth-1:0] bregAddr,
    output logic [cpuPkg::dataWidth-1:0]    dataA,
    output logic [cpuPkg::dataWidth-1:0]    dataB,
    input  logic                            flush,
    input  logic [cpuPkg::regAddrWidth-1:0] wbReg,
    input  logic [cpuPkg::dataWidth-1:0]    wbData,
    input  logic                            wbWe
);
    import cpuPkg::*;

    logic [dataWidth-1:0] regs [numRegs];

    function automatic logic [dataWidth-1:0] readPort(input logic [regAddrWidth-1:0] addr);
        if (addr == '0)
            return '0;
        // value being written this cycle goes straight to the reader
        else if (wbWe && wbReg == addr)
            return wbData;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk)
    begin
        if (wbWe && wbReg != '0)
            regs[wbReg] <= wbData;
    end

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            dataA <= '0;
            dataB <= '0;
        end
        else
        begin
            dataA <= readPort(aregAddr);
            dataB <= readPort(bregAddr);
        end
    end

    // the decoder keeps register 0 out of write back, so it stays zero
    noWriteToZero: assert property (@(posedge clk) disable iff (reset)
        wbWe |-> (wbReg != '0));

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps
// execute-stage arithmetic and logic unit
// add, sub, and, or, xor, shifts and signed set-less-than
module alu (
    input  logic [cpuPkg::aluOpWidth-1:0] aluOp,
    input  logic [cpuPkg::dataWidth-1:0]  a,
    input  logic [cpuPkg::dataWidth-1:0]  b,
    output logic [cpuPkg::dataWidth-1:0]  y
);
    import cpuPkg::*;

    logic [4:0] shamt;

    // shifts only look at the low five bits
    assign shamt = b[4:0];

    always_comb
    begin
        case (aluOp)
            aluAdd:  y = a + b;
            aluSub:  y = a - b;
            aluAnd:  y = a & b;
            aluOr:   y = a | b;
            aluXor:  y = a ^ b;
            aluShl:  y = a << shamt;
            aluShr:  y = a >> shamt;
            aluSlt:  y = {{(dataWidth - 1){1'b0}}, $signed(a) < $signed(b)};
            default: y = '0;
        endcase
    end

endmodule

//--- hw/branchUnit.sv
`timescale 1ns/1ps
// MEM-stage branch resolution
// signed or unsigned compare of the forwarded operands
// redirect and target for branch, jump, register jump and halt
module branchUnit (
    input  logic                             isBranch,
    input  logic                             isJump,
    input  logic                             isJumpR,
    input  logic                             isHalt,
    input  logic [cpuPkg::branchOpWidth-1:0] branchOp,
    input  logic                             isSigned,
    input  logic [cpuPkg::dataWidth-1:0]     a,
    input  logic [cpuPkg::dataWidth-1:0]     b,
    input  logic [cpuPkg::addrWidth-1:0]     pcMem,
    input  logic [cpuPkg::dataWidth-1:0]     const12Ext,
    input  logic [cpuPkg::addrWidth-1:0]     jumpTarget,
    output logic                             redirect,
    output logic [cpuPkg::addrWidth-1:0]     redirectAddr
);
    import cpuPkg::*;

    logic                 equal;
    logic                 lessThan;
    logic                 passed;
    logic [dataWidth-1:0] regTarget;

    assign equal    = (a == b);
    // one ordering serves all relational compares
    assign lessThan = isSigned ? ($signed(a) < $signed(b)) : (a < b);

    always_comb
    begin
        case (branchOp)
            brEq:    passed = equal;
            brGt:    passed = !lessThan && !equal;
            brGe:    passed = !lessThan;
            brNe:    passed = !equal;
            brLt:    passed = lessThan;
            brLe:    passed = lessThan || equal;
            default: passed = 1'b0;
        endcase
    end

    assign regTarget = b + const12Ext;
    assign redirect  = (isBranch && passed) || isJump || isJumpR || isHalt;

    always_comb
    begin
        if (isJump)
            redirectAddr = jumpTarget;
        else if (isJumpR)
            redirectAddr = regTarget[addrWidth-1:0];
        else if (isBranch)
            redirectAddr = pcMem + const12Ext[addrWidth-1:0];
        else
            redirectAddr = pcMem; // halt spins on its own address
    end

    always_comb
    begin
        // each decoded instruction carries at most one transfer flag down the pipe
        assert ($onehot0({isBranch, isJump, isJumpR, isHalt}));
    end

endmodule

//--- hw/hazardUnit.sv
`timescale 1ns/1ps
// forwarding selects for the EX operands
// MEM has priority over WB, register 0 never forwards
// flush of FE, DE and EX on a taken redirect
module hazardUnit (
    input  logic [cpuPkg::regAddrWidth-1:0] aregEx,
    input  logic [cpuPkg::regAddrWidth-1:0] bregEx,
    input  logic [cpuPkg::regAddrWidth-1:0] dregMem,
    input  logic [cpuPkg::regAddrWidth-1:0] dregWb,
    input  logic                            regWeMem,
    input  logic                            regWeWb,
    input  logic                            redirect,
    output logic [cpuPkg::fwdWidth-1:0]     fwdA,
    output logic [cpuPkg::fwdWidth-1:0]     fwdB,
    output logic                            flushFront
);
    import cpuPkg::*;

    function automatic logic [fwdWidth-1:0] pickSource(input logic [regAddrWidth-1:0] src);
        if (src == '0)
            return fwdNone;
        else if (regWeMem && dregMem == src)
            return fwdMem;
        else if (regWeWb && dregWb == src)
            return fwdWb;
        else
            return fwdNone;
    endfunction

    always_comb
    begin
        fwdA = pickSource(aregEx);
        fwdB = pickSource(bregEx);
    end

    assign flushFront = redirect;

endmodule

//--- hw/cpuCore.sv
`timescale 1ns/1ps
// five-stage core top level
// FE/DE, DE/EX, EX/MEM and MEM/WB stage registers
// forwarding muxes and ALU operand b select
// counter, decoder, register bank, ALU, branch and hazard units
module cpuCore (
    input  logic                            clk,
    input  logic                            reset,
    output logic [cpuPkg::addrWidth-1:0]    romAddr,
    input  logic [cpuPkg::dataWidth-1:0]    romData,
    output logic                            halted,
    output logic                            wbWe,
    output logic [cpuPkg::regAddrWidth-1:0] wbReg,
    output logic [cpuPkg::dataWidth-1:0]    wbData
);
    import cpuPkg::*;

    logic                    redirect;
    logic                    flushFront;
    logic [addrWidth-1:0]    redirectAddr;
    logic [fwdWidth-1:0]     fwdA;
    logic [fwdWidth-1:0]     fwdB;

    // decode stage
    logic [dataWidth-1:0]    instrDe;
    logic [addrWidth-1:0]    pcDe;
    logic [aluOpWidth-1:0]   aluOpDe;
    logic [branchOpWidth-1:0] branchOpDe;
    logic [dataWidth-1:0]    constDe;
    logic [regAddrWidth-1:0] aregDe, bregDe, dregDe;
    logic isSignedDe, useConstDe, regWeDe, isBranchDe, isJumpDe, isJumpRDe, isHaltDe;

    // execute stage
    logic [addrWidth-1:0]    pcEx, jumpTargetEx;
    logic [aluOpWidth-1:0]   aluOpEx;
    logic [branchOpWidth-1:0] branchOpEx;
    logic [dataWidth-1:0]    constEx, dataAEx, dataBEx;
    logic [dataWidth-1:0]    opAEx, regBEx, opBEx, aluResultEx;
    logic [regAddrWidth-1:0] aregEx, bregEx, dregEx;
    logic isSignedEx, useConstEx, regWeEx, isBranchEx, isJumpEx, isJumpREx, isHaltEx;

    // memory stage
    logic [addrWidth-1:0]    pcMem, jumpTargetMem;
    logic [branchOpWidth-1:0] branchOpMem;
    logic [dataWidth-1:0]    constMem, aMem, bMem, resultMem;
    logic [regAddrWidth-1:0] dregMem;
    logic isSignedMem, regWeMem, isBranchMem, isJumpMem, isJumpRMem, isHaltMem;

    programCounter pcUnit (.clk, .reset, .redirect, .redirectAddr, .haltMem(isHaltMem),
                           .romAddr, .halted);

    // FE/DE holds the fetched word with its address
    always_ff @(posedge clk)
    begin
        if (reset || flushFront)
            instrDe <= nopWord;
        else
            instrDe <= romData;
        pcDe <= romAddr;
    end

    instrDecoder decoder (.instr(instrDe), .aluOp(aluOpDe), .branchOp(branchOpDe),
                          .isSigned(isSignedDe), .const12Ext(constDe), .areg(aregDe),
                          .breg(bregDe), .dreg(dregDe), .useConst(useConstDe),
                          .regWe(regWeDe), .isBranch(isBranchDe), .isJump(isJumpDe),
                          .isJumpR(isJumpRDe), .isHalt(isHaltDe));

    // register reads land directly in EX
    regBank registers (.clk, .reset, .aregAddr(aregDe), .bregAddr(bregDe), .dataA(dataAEx),
                       .dataB(dataBEx), .flush(flushFront), .wbReg, .wbData, .wbWe);

    always_ff @(posedge clk)
    begin
        if (reset || flushFront)
        begin
            regWeEx    <= 1'b0;
            isBranchEx <= 1'b0;
            isJumpEx   <= 1'b0;
            isJumpREx  <= 1'b0;
            isHaltEx   <= 1'b0;
        end
        else
        begin
            regWeEx    <= regWeDe;
            isBranchEx <= isBranchDe;
            isJumpEx   <= isJumpDe;
            isJumpREx  <= isJumpRDe;
            isHaltEx   <= isHaltDe;
        end
        pcEx         <= pcDe;
        jumpTargetEx <= instrDe[addrWidth-1:0];
        aluOpEx      <= aluOpDe;
        branchOpEx   <= branchOpDe;
        isSignedEx   <= isSignedDe;
        useConstEx   <= useConstDe;
        constEx      <= constDe;
        aregEx       <= aregDe;
        bregEx       <= bregDe;
        dregEx       <= dregDe;
    end

    hazardUnit hazards (.aregEx, .bregEx, .dregMem, .dregWb(wbReg), .regWeMem,
                        .regWeWb(wbWe), .redirect, .fwdA, .fwdB, .flushFront);

    always_comb
    begin
        case (fwdA)
            fwdMem:  opAEx = resultMem;
            fwdWb:   opAEx = wbData;
            default: opAEx = dataAEx;
        endcase
        case (fwdB)
            fwdMem:  regBEx = resultMem;
            fwdWb:   regBEx = wbData;
            default: regBEx = dataBEx;
        endcase
    end

    // the constant replaces the forwarded register value
    assign opBEx = useConstEx ? constEx : regBEx;

    alu execUnit (.aluOp(aluOpEx), .a(opAEx), .b(opBEx), .y(aluResultEx));

    always_ff @(posedge clk)
    begin
        if (reset || flushFront)
        begin
            regWeMem    <= 1'b0;
            isBranchMem <= 1'b0;
            isJumpMem   <= 1'b0;
            isJumpRMem  <= 1'b0;
            isHaltMem   <= 1'b0;
        end
        else
        begin
            regWeMem    <= regWeEx;
            isBranchMem <= isBranchEx;
            isJumpMem   <= isJumpEx;
            isJumpRMem  <= isJumpREx;
            isHaltMem   <= isHaltEx;
        end
        pcMem         <= pcEx;
        jumpTargetMem <= jumpTargetEx;
        branchOpMem   <= branchOpEx;
        isSignedMem   <= isSignedEx;
        constMem      <= constEx;
        aMem          <= opAEx;
        bMem          <= regBEx;
        resultMem     <= aluResultEx;
        dregMem       <= dregEx;
    end

    branchUnit resolver (.isBranch(isBranchMem), .isJump(isJumpMem), .isJumpR(isJumpRMem),
                         .isHalt(isHaltMem), .branchOp(branchOpMem), .isSigned(isSignedMem),
                         .a(aMem), .b(bMem), .pcMem, .const12Ext(constMem),
                         .jumpTarget(jumpTargetMem), .redirect, .redirectAddr);

    // MEM/WB is the register bank write port
    always_ff @(posedge clk)
    begin
        if (reset)
            wbWe <= 1'b0;
        else
            wbWe <= regWeMem;
        wbReg  <= dregMem;
        wbData <= resultMem;
    end

endmodule

//--- verif/cpuTb.sv
`timescale 1ns/1ps
// testbench for the five-stage core
// clock, reset and a ROM model driven on the falling edge
// programs and expected write-back streams read from the pattern file
// stream, halt and quiet checks, each program run twice across a reset
module cpuTb;
    import cpuPkg::*;

    localparam int romDepth      = 1 << addrWidth;
    localparam int patternBits   = 10;
    localparam int patternDepth  = 1 << patternBits;
    localparam int timeoutCycles = 200;
    localparam int quietCycles   = 20;
    localparam logic [3:0] haltOpcode = 4'd6;

    logic                    clk = 1'b0;
    logic                    reset = 1'b1;
    logic [addrWidth-1:0]    romAddr;
    logic [dataWidth-1:0]    romData = '0;
    logic                    halted;
    logic                    wbWe;
    logic [regAddrWidth-1:0] wbReg;
    logic [dataWidth-1:0]    wbData;

    logic [dataWidth-1:0] rom [romDepth];
    logic [31:0]          patterns [patternDepth];
    integer               seed = 32'h9f9bbf4a;
    int                   errors = 0;
    int                   testsFailed = 0;

    cpuCore UUT (.clk, .reset, .romAddr, .romData, .halted, .wbWe, .wbReg, .wbData);

    always #5 clk = ~clk;

    // ROM answers the current address on the falling edge
    always @(negedge clk)
    begin
        romData <= rom[romAddr];
    end

    function automatic logic [31:0] patternWord(input int pos);
        return patterns[patternBits'(pos)];
    endfunction

    function automatic string testName(input int index);
        case (index)
            1:       return "aluChain";
            2:       return "constAndZero";
            3:       return "branches";
            4:       return "jumps";
            5:       return "haltLoop";
            default: return $sformatf("test%0d", index);
        endcase
    endfunction

    task automatic compareValue(input string label, input logic [dataWidth-1:0] expected,
                                input logic [dataWidth-1:0] actual);
        if (actual !== expected)
        begin
            $display("Mismatch %s: expected %h, actual %h", label, expected, actual);
            errors++;
        end
    endtask

    // program at the bottom, random words above it with the halt opcode removed
    task automatic loadRom(input int progBase, input int length);
        logic [dataWidth-1:0] word;
        int                   i;
        for (i = 0; i < romDepth; i++)
        begin
            if (i < length)
                rom[addrWidth'(i)] = patternWord(progBase + i);
            else
            begin
                word = $random(seed);
                if (word[31:28] == haltOpcode)
                    word[31:28] = 4'hf;
                rom[addrWidth'(i)] = word;
            end
        end
    endtask

    task automatic holdReset;
        reset = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic flagStrayWrite(input string name, input int run);
        if (wbWe)
        begin
            $display("%s run %0d: unexpected write-back to register %h", name, run, wbReg);
            errors++;
        end
    endtask

    task automatic checkStream(input string name, input int run, input int pairBase,
                               input int count);
        string label;
        int    k;
        int    waited;
        for (k = 0; k < count; k++)
        begin
            waited = 0;
            do
            begin
                @(negedge clk);
                waited++;
            end while (!wbWe && waited < timeoutCycles);
            if (!wbWe)
            begin
                $display("%s run %0d: write-back %0d of %0d is missing", name, run, k + 1,
                         count);
                errors++;
                return;
            end
            label = $sformatf("%s run %0d write %0d", name, run, k + 1);
            compareValue({label, " register"}, patternWord(pairBase + 2 * k),
                         dataWidth'(wbReg));
            compareValue({label, " value"}, patternWord(pairBase + 2 * k + 1), wbData);
        end
        // no write may slip in before halted rises
        waited = 0;
        while (!halted && waited < timeoutCycles)
        begin
            @(negedge clk);
            waited++;
            flagStrayWrite(name, run);
        end
        if (!halted)
        begin
            $display("%s run %0d: the program never halted", name, run);
            errors++;
            return;
        end
        repeat (quietCycles)
        begin
            @(negedge clk);
            flagStrayWrite(name, run);
        end
    endtask

    task automatic runTest(input int index, input int length, input int count,
                           input int progBase);
        string name;
        int    errorsBefore;
        int    run;
        name = testName(index);
        errorsBefore = errors;
        loadRom(progBase, length);
        // the second run starts from a halted core
        for (run = 1; run <= 2; run++)
        begin
            holdReset();
            compareValue($sformatf("%s run %0d romAddr after reset", name, run), '0,
                         dataWidth'(romAddr));
            compareValue($sformatf("%s run %0d halted after reset", name, run), '0,
                         dataWidth'(halted));
            compareValue($sformatf("%s run %0d wbWe after reset", name, run), '0,
                         dataWidth'(wbWe));
            checkStream(name, run, progBase + length, count);
        end
        if (errors == errorsBefore)
            $display("test %0d %s passed", index, name);
        else
        begin
            $display("test %0d %s failed with %0d errors", index, name, errors - errorsBefore);
            testsFailed++;
        end
    endtask

    initial
    begin
        int numTests;
        int cursor;
        int t;
        int index;
        int length;
        int count;
        $readmemh("verif/cpuPatterns.txt", patterns);
        numTests = patternWord(0);
        cursor = 1;
        for (t = 0; t < numTests; t++)
        begin
            index  = patternWord(cursor);
            length = patternWord(cursor + 1);
            count  = patternWord(cursor + 2);
            runTest(index, length, count, cursor + 3);
            cursor = cursor + 3 + length + 2 * count;
        end
        $display("%0d tests run, %0d failed, %0d errors", numTests, testsFailed, errors);
        if (errors == 0 && testsFailed == 0 && numTests > 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- verif/cpuPatterns.txt
// first word is the number of tests, then per test: index, program length, write count
// then the program words, then the expected (register, value) write-back pairs, all hex
5
// dependent register-register chain, MEM over WB at the end
1 e d
20005001 20003002 10000123 11000314 14000435 15000546 13000617
12000768 16000829 1700029a 2000700b 10000bbb 10000b0c 60000000
1 5  2 3  3 8  4 3  5 b  6 58  7 5d
8 58  9 b  a 1  b 7  b e  c e
// negative constants, a dropped write to r0 and a read of r0
2 9 7
20fff001 20800102 22f00203 27fff304 20064000 10000045 21007006
2601c607 60000000
1 ffffffff  2 fffff7ff  3 fffff700  4 1
5 1  6 fffffff9  7 f
// signed and unsigned compares of 1 and -1
3 15 6
20001001 20fff002 3b005210 20111003 20222003 20333003 20444003
20001004 3a003210 20002005 32004210 20555006 20666006 20777006
33004210 20003007 38003120 20888008 20999008 11000129 60000000
1 1  2 ffffffff  4 1  5 2  7 3  9 2
// absolute jump, then register jump through a forwarded register
4 e 4
2000a001 40000005 20111002 20222002 20333002 20055003 20fff104
50003040 20777005 20888005 20999005 20aaa005 10000436 60000000
1 a  3 55  4 9  6 5e
// countdown loop with a halt in the taken-branch shadow
5 8 8
20003001 20000002 10000212 20fff111 38ffe100 60000000 20777003 20888003
1 3  2 0  2 3  1 2  2 5  1 1  2 6  1 0

//--- files.f
hw/cpuPkg.sv
hw/instrDecoder.sv
hw/programCounter.sv
hw/regBank.sv
hw/alu.sv
hw/branchUnit.sv
hw/hazardUnit.sv
hw/cpuCore.sv
verif/cpuTb.sv

//--- run.sh
#!/bin/sh
# build the core testbench with Verilator, run it and decide from the log
set -e
verilator --binary --assert --timing -f files.f --top-module cpuTb -o cpuTb
./obj_dir/cpuTb | tee sim.log
grep -q '^>>> PASS$' sim.log
